// File: Makefile
# Verilator build and run of the cache testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module cacheTb \
		--Mdir obj_dir -o cacheSim
	./obj_dir/cacheSim +verilator+error+limit+1000 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: flist.f
src/cachePkg.sv
src/plruPolicy.sv
src/tagStore.sv
src/dataStore.sv
src/cacheSequencer.sv
src/cacheTop.sv
tests/cacheCtl_properties.sv
tests/cacheTb.sv

// File: src/cachePkg.sv
/*
 * Shared widths and state encoding for the 4-way read cache.
 * NumWays is fixed at 4 by the 3-bit pseudo-LRU tree.
 */
package cachePkg;

	localparam int DataWidth = 16;	// CPU and DRAM word width
	localparam int NumWays   = 4;	// ways per set, tied to the 3-bit tree
	localparam int WayBits   = 2;	// bits to number a way

	// controller states
	typedef enum logic [3:0] {
		sInvalidate,	// post-reset sweep, one set per cycle
		sIdle,
		sLookup,	// tag compare result is used here
		sHitDtack,
		sFillRequest,	// waiting for a CAS read from the DRAM controller
		sCasWait,
		sBurstFill,
		sFillDtack,
		sWriteThrough
	} cacheState_t;

	// one-hot (or zero) way vector to way number
	function automatic logic [WayBits-1:0] wayIndex(input logic [NumWays-1:0] ways);
		logic [WayBits-1:0] idx;
		idx = '0;
		for (int w = 0; w < NumWays; w++)
			if (ways[w]) idx = WayBits'(w);	// highest set bit wins
		return idx;
	endfunction

endpackage

// File: src/cacheSequencer.sv
/*
 * Bus FSM for the cache: lookup, line fill, write-through and the reset sweep.
 * First fill word is taken CasLatency cycles after CAS low with RAS high (CasLatency >= 2).
 */
`timescale 1ns/100ps

module cacheSequencer #(
	parameter int AddrWidth  = 32,
	parameter int SetBits    = 3,
	parameter int WordBits   = 3,
	parameter int CasLatency = 2
) (
	input  logic                           Clock,
	input  logic                           Reset_L,
	input  logic [AddrWidth-1:0]           cpuAddr,
	input  logic                           as_L,
	input  logic                           we_L,
	input  logic                           uds_L,
	input  logic                           lds_L,
	input  logic                           dramSelectCpu,
	input  logic                           dramDtack_L,
	input  logic                           dramCas_L,
	input  logic                           dramRas_L,
	input  logic [cachePkg::NumWays-1:0]   hitWays,
	input  logic [cachePkg::WayBits-1:0]   victimWay,
	output logic                           dtack_L,
	output logic                           dramSelect_L,
	output logic [AddrWidth-1:0]           dramAddr,
	output logic                           dramUds_L,
	output logic                           dramLds_L,
	output logic                           dramWe_L,
	output logic                           dramAs_L,
	output logic [SetBits-1:0]             setIndex,
	output logic [WordBits-1:0]            wordIndex,
	output logic [cachePkg::WayBits-1:0]   readWay,
	output logic [cachePkg::NumWays-1:0]   tagWe,
	output logic [cachePkg::NumWays-1:0]   validWe,
	output logic                           validIn,
	output logic                           tagClear,
	output logic [cachePkg::NumWays-1:0]   dataWe,
	output logic                           lruHitUpdate,
	output logic                           lruFill,
	output logic                           lruClear
);

	localparam int CntBits   = (SetBits > WordBits) ? SetBits : WordBits;	// sweep or burst
	localparam int NumSets   = 1 << SetBits;
	localparam int LineWords = 1 << WordBits;

	cachePkg::cacheState_t        state, nextState;
	logic [CntBits-1:0]           count;		// restarts at zero in every new state
	logic [cachePkg::WayBits-1:0] victimReg;	// way being filled
	logic [cachePkg::NumWays-1:0] victimMask;
	logic                         cpuGone;		// CPU has ended its bus cycle

	assign cpuGone    = as_L || !dramSelectCpu;
	assign victimMask = {{(cachePkg::NumWays-1){1'b0}}, 1'b1} << victimReg;

	////////////////////////////////////////////////////////////
	// state and counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= cachePkg::sInvalidate;	// sweep starts right out of reset
			count <= '0;
		end else begin
			state <= nextState;
			if (nextState != state)
				count <= '0;
			else
				count <= count + 1'b1;	// free running otherwise, wrap is harmless
		end
	end

	always_ff @(posedge Clock) begin
		if (state == cachePkg::sLookup)
			victimReg <= victimWay;	// held through the whole fill
	end

	////////////////////////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////////////////////////
	always_comb begin
		nextState    = state;
		dtack_L      = 1'b1;
		dramSelect_L = 1'b1;
		dramAddr     = {cpuAddr[AddrWidth-1:WordBits+1], {(WordBits+1){1'b0}}};	// line aligned
		dramUds_L    = uds_L;
		dramLds_L    = lds_L;
		dramWe_L     = we_L;
		dramAs_L     = as_L;
		setIndex     = cpuAddr[SetBits+WordBits:WordBits+1];
		wordIndex    = cpuAddr[WordBits:1];
		readWay      = cachePkg::wayIndex(hitWays);
		tagWe        = '0;
		validWe      = '0;
		validIn      = 1'b0;
		tagClear     = 1'b0;
		dataWe       = '0;
		lruHitUpdate = 1'b0;
		lruFill      = 1'b0;
		lruClear     = 1'b0;

		case (state)
			cachePkg::sInvalidate: begin
				setIndex = count[SetBits-1:0];	// one set per cycle
				tagWe    = '1;
				validWe  = '1;
				tagClear = 1'b1;
				lruClear = 1'b1;
				if (count == CntBits'(NumSets - 1))
					nextState = cachePkg::sIdle;
			end
			cachePkg::sIdle: begin
				if (!as_L && dramSelectCpu) begin
					if (we_L)
						nextState = cachePkg::sLookup;
					else begin
						validWe   = hitWays;	// drop any cached copy, no write allocate
						nextState = cachePkg::sWriteThrough;
					end
				end
			end
			cachePkg::sLookup: begin
				dramUds_L = 1'b0;	// always fetch the whole word
				dramLds_L = 1'b0;
				if (|hitWays) begin
					dtack_L      = 1'b0;
					lruHitUpdate = 1'b1;
					nextState    = cachePkg::sHitDtack;
				end else begin
					dramSelect_L = 1'b0;	// start the DRAM read early
					lruFill      = 1'b1;	// tree moves off the victim now
					nextState    = cachePkg::sFillRequest;
				end
			end
			cachePkg::sHitDtack: begin
				dtack_L = 1'b0;
				if (cpuGone)
					nextState = cachePkg::sIdle;
			end
			cachePkg::sFillRequest: begin
				dramSelect_L = 1'b0;
				dramUds_L    = 1'b0;
				dramLds_L    = 1'b0;
				if (!dramCas_L && dramRas_L)	// CAS read, not a refresh
					nextState = cachePkg::sCasWait;
			end
			cachePkg::sCasWait: begin
				dramSelect_L = 1'b0;
				dramUds_L    = 1'b0;
				dramLds_L    = 1'b0;
				if (count == CntBits'(CasLatency - 2))
					nextState = cachePkg::sBurstFill;
			end
			cachePkg::sBurstFill: begin
				dramSelect_L = 1'b0;
				dramUds_L    = 1'b0;
				dramLds_L    = 1'b0;
				wordIndex    = count[WordBits-1:0];
				dataWe       = victimMask;
				if (count == CntBits'(LineWords - 1)) begin
					tagWe     = victimMask;	// line becomes valid with its last word
					validWe   = victimMask;
					validIn   = 1'b1;
					nextState = cachePkg::sFillDtack;
				end
			end
			cachePkg::sFillDtack: begin
				dtack_L   = 1'b0;
				readWay   = victimReg;
				dramUds_L = 1'b0;
				dramLds_L = 1'b0;
				if (cpuGone)
					nextState = cachePkg::sIdle;
			end
			cachePkg::sWriteThrough: begin
				dramSelect_L = 1'b0;
				dramAddr     = cpuAddr;	// exact address, CPU strobes
				dtack_L      = dramDtack_L;
				if (cpuGone)
					nextState = cachePkg::sIdle;
			end
			default: nextState = cachePkg::sIdle;
		endcase
	end

endmodule

// File: src/cacheTop.sv
/*
 * 4-way set-associative read cache between a 68000-style bus and a DRAM controller.
 * Writes pass through and invalidate; reads allocate with a full line burst.
 * CasLatency must be 2 or more; requests are ignored during the post-reset sweep.
 */
`timescale 1ns/100ps

module cacheTop #(
	parameter int AddrWidth  = 32,
	parameter int SetBits    = 3,
	parameter int WordBits   = 3,
	parameter int CasLatency = 2
) (
	input  logic                           Clock,
	input  logic                           Reset_L,
	// CPU side
	input  logic [AddrWidth-1:0]           cpuAddr,
	input  logic [cachePkg::DataWidth-1:0] cpuWriteData,
	output logic [cachePkg::DataWidth-1:0] cpuReadData,
	input  logic                           as_L,
	input  logic                           uds_L,
	input  logic                           lds_L,
	input  logic                           we_L,
	input  logic                           dramSelectCpu,	// active high decode from CPU
	output logic                           dtack_L,
	// DRAM controller side
	output logic                           dramSelect_L,
	output logic [AddrWidth-1:0]           dramAddr,
	output logic [cachePkg::DataWidth-1:0] dramWriteData,
	output logic                           dramUds_L,
	output logic                           dramLds_L,
	output logic                           dramWe_L,
	output logic                           dramAs_L,
	input  logic [cachePkg::DataWidth-1:0] dramReadData,
	input  logic                           dramDtack_L,
	input  logic                           dramCas_L,
	input  logic                           dramRas_L
);

	logic [SetBits-1:0]           setIndex;
	logic [WordBits-1:0]          wordIndex;
	logic [cachePkg::WayBits-1:0] readWay, victimWay;
	logic [cachePkg::NumWays-1:0] hitWays, tagWe, validWe, dataWe;
	logic                         validIn, tagClear;
	logic                         lruHitUpdate, lruFill, lruClear;

	assign dramWriteData = cpuWriteData;	// write data goes straight to DRAM

	cacheSequencer #(
		.AddrWidth(AddrWidth), .SetBits(SetBits),
		.WordBits(WordBits), .CasLatency(CasLatency)
	) seq0 (.*);

	tagStore #(
		.AddrWidth(AddrWidth), .SetBits(SetBits), .WordBits(WordBits)
	) tags0 (.*);

	dataStore #(.SetBits(SetBits), .WordBits(WordBits)) data0 (.*);

	plruPolicy #(.SetBits(SetBits)) lru0 (.*);

endmodule

// File: src/dataStore.sv
/*
 * Line data per way, addressed by set and word within the line.
 * Read is combinational from readWay; no reset on the array.
 */
`timescale 1ns/100ps

module dataStore #(
	parameter int SetBits  = 3,
	parameter int WordBits = 3
) (
	input  logic                           Clock,
	input  logic [SetBits-1:0]             setIndex,
	input  logic [WordBits-1:0]            wordIndex,
	input  logic [cachePkg::NumWays-1:0]   dataWe,
	input  logic [cachePkg::WayBits-1:0]   readWay,
	input  logic [cachePkg::DataWidth-1:0] dramReadData,
	output logic [cachePkg::DataWidth-1:0] cpuReadData
);

	localparam int Depth = 1 << (SetBits + WordBits);	// words per way

	logic [cachePkg::DataWidth-1:0] dataMem [cachePkg::NumWays][Depth];
	logic [SetBits+WordBits-1:0]    wordAddr;

	assign wordAddr = {setIndex, wordIndex};

	always_ff @(posedge Clock) begin
		for (int w = 0; w < cachePkg::NumWays; w++)
			if (dataWe[w])
				dataMem[w][wordAddr] <= dramReadData;	// burst word from DRAM
	end

	assign cpuReadData = dataMem[readWay][wordAddr];

endmodule

// File: src/plruPolicy.sv
/*
 * 3-bit tree pseudo-LRU per set, 4 ways only.
 * Victim is read combinationally at setIndex; updates land on the clock edge.
 */
`timescale 1ns/100ps

module plruPolicy #(
	parameter int SetBits = 3
) (
	input  logic                         Clock,
	input  logic                         Reset_L,
	input  logic [SetBits-1:0]           setIndex,
	input  logic [cachePkg::NumWays-1:0] hitWays,
	input  logic                         lruHitUpdate,
	input  logic                         lruFill,
	input  logic                         lruClear,
	output logic [cachePkg::WayBits-1:0] victimWay
);

	localparam int NumSets = 1 << SetBits;

	// bit 0 picks the pair, bit 1 way 0/1, bit 2 way 2/3
	logic [2:0]                   lruMem [NumSets];
	logic [2:0]                   curBits, newBits;
	logic [cachePkg::WayBits-1:0] usedWay;

	assign curBits   = lruMem[setIndex];
	assign victimWay = curBits[0] ? {1'b1, curBits[2]} : {1'b0, curBits[1]};
	assign usedWay   = lruFill ? victimWay : cachePkg::wayIndex(hitWays);

	// point every node on the path away from the used way
	always_comb begin
		newBits    = curBits;
		newBits[0] = ~usedWay[1];
		if (usedWay[1])
			newBits[2] = ~usedWay[0];
		else
			newBits[1] = ~usedWay[0];
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int s = 0; s < NumSets; s++)
				lruMem[s] <= '0;
		end else if (lruClear)
			lruMem[setIndex] <= '0;
		else if (lruHitUpdate || lruFill)
			lruMem[setIndex] <= newBits;
	end

endmodule

// File: src/tagStore.sv
/*
 * Tag and valid bit per way per set, with combinational compare at setIndex.
 * Tags carry the address bits above set and word; byte bit 0 is ignored.
 */
`timescale 1ns/100ps

module tagStore #(
	parameter int AddrWidth = 32,
	parameter int SetBits   = 3,
	parameter int WordBits  = 3
) (
	input  logic                         Clock,
	input  logic                         Reset_L,
	input  logic [SetBits-1:0]           setIndex,
	input  logic [AddrWidth-1:0]         cpuAddr,
	input  logic [cachePkg::NumWays-1:0] tagWe,
	input  logic [cachePkg::NumWays-1:0] validWe,
	input  logic                         validIn,
	input  logic                         tagClear,	// write zero instead of the CPU tag
	output logic [cachePkg::NumWays-1:0] hitWays
);

	localparam int TagWidth = AddrWidth - SetBits - WordBits - 1;
	localparam int NumSets  = 1 << SetBits;

	logic [TagWidth-1:0] tagMem   [cachePkg::NumWays][NumSets];
	logic [NumSets-1:0]  validMem [cachePkg::NumWays];	// one bit per set
	logic [TagWidth-1:0] cpuTag, tagIn;

	assign cpuTag = cpuAddr[AddrWidth-1:AddrWidth-TagWidth];
	assign tagIn  = tagClear ? '0 : cpuTag;

	always_ff @(posedge Clock) begin
		for (int w = 0; w < cachePkg::NumWays; w++)
			if (tagWe[w])
				tagMem[w][setIndex] <= tagIn;
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int w = 0; w < cachePkg::NumWays; w++)
				validMem[w] <= '0;
		end else begin
			for (int w = 0; w < cachePkg::NumWays; w++)
				if (validWe[w])
					validMem[w][setIndex] <= validIn;
		end
	end

	////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int w = 0; w < cachePkg::NumWays; w++)
			hitWays[w] = validMem[w][setIndex] && (tagMem[w][setIndex] == cpuTag);
	end

endmodule

// File: tests/cacheCtl_properties.sv
/*
 * Bus and DRAM protocol assertions for cacheTop, attached with bind.
 * failCount holds the number of failed assertions for the testbench.
 */
`timescale 1ns/100ps

module cacheCtlProperties #(
	parameter int AddrWidth = 32
) (
	input logic                 Clock,
	input logic                 Reset_L,
	input logic                 as_L,
	input logic                 uds_L,
	input logic                 lds_L,
	input logic                 dramSelectCpu,
	input logic                 dtack_L,
	input logic                 dramSelect_L,
	input logic [AddrWidth-1:0] dramAddr,
	input logic                 dramUds_L,
	input logic                 dramLds_L,
	input logic                 dramWe_L
);

	int failCount = 0;	// read by the testbench at the end

	// nothing acknowledged or selected while in reset
	resetQuiet: assert property (@(posedge Clock) !Reset_L |-> (dtack_L && dramSelect_L))
		else begin
			failCount++;
			$error("dtack_L or dramSelect_L low during reset");
		end

	// dtack held until the CPU ends its cycle
	dtackHold: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!dtack_L && !as_L && dramSelectCpu) |=> (!dtack_L || as_L || !dramSelectCpu))
		else begin
			failCount++;
			$error("dtack_L released while as_L still low");
		end

	////////////////////////////////////////////////////////////
	// DRAM side
	////////////////////////////////////////////////////////////
	fillShape: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!dramSelect_L && dramWe_L) |-> (!dramUds_L && !dramLds_L && dramAddr[3:0] == 4'h0))
		else begin
			failCount++;
			$error("line fill without both strobes or not line aligned");
		end

	writeStrobes: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!dramSelect_L && !dramWe_L) |-> (dramUds_L == uds_L && dramLds_L == lds_L))
		else begin
			failCount++;
			$error("DRAM byte strobes differ from CPU strobes on a write");
		end

endmodule

bind cacheTop cacheCtlProperties #(.AddrWidth(AddrWidth)) props0 (
	.Clock(Clock), .Reset_L(Reset_L), .as_L(as_L), .uds_L(uds_L), .lds_L(lds_L),
	.dramSelectCpu(dramSelectCpu), .dtack_L(dtack_L), .dramSelect_L(dramSelect_L),
	.dramAddr(dramAddr), .dramUds_L(dramUds_L), .dramLds_L(dramLds_L), .dramWe_L(dramWe_L)
);

// File: tests/cacheTb.sv
/*
 * Testbench for cacheTop with a DRAM controller model and a shadow memory.
 * Shadow covers byte addresses below 8K; all test addresses stay in that range.
 */
`timescale 1ns/100ps

module cacheTb;

	localparam int CasLatency = 2;
	localparam int MaxWait    = 100;	// cycles before any wait gives up

	logic        Clock, Reset_L;
	logic [31:0] cpuAddr, dramAddr;
	logic [15:0] cpuWriteData, cpuReadData, dramWriteData, dramReadData;
	logic        as_L, uds_L, lds_L, we_L, dramSelectCpu, dtack_L;
	logic        dramSelect_L, dramUds_L, dramLds_L, dramWe_L, dramAs_L;
	logic        dramDtack_L, dramCas_L, dramRas_L;

	logic [15:0] shadow [4096];	// indexed by byte address bits 12:1
	int          errors       = 0;
	int          timeouts     = 0;
	int          dramErrors   = 0;	// counted by the DRAM model
	int          dramTimeouts = 0;
	int          fillCount    = 0;	// line reads seen by the DRAM model
	logic [1:0]  lastVictim;		// way chosen for the latest fill

	cacheTop #(.CasLatency(CasLatency)) dut0 (.*);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;	// 100 ns period
	end

	// DRAM model side: wait until the cache drops its select
	task automatic waitRelease(input string what);
		int cycles;
		cycles = 0;
		do begin
			@(negedge Clock);
			cycles++;
		end while (!dramSelect_L && cycles < MaxWait);
		if (!dramSelect_L) begin
			dramTimeouts++;
			$display("Timed out waiting for dramSelect_L to rise after a DRAM %s", what);
		end
	endtask

	////////////////////////////////////////////////////////////
	// DRAM controller model
	////////////////////////////////////////////////////////////
	initial begin : dramModel
		int          seed;
		logic [8:0]  fillLine;
		logic [11:0] wordAddr;
		seed = 32'hc2d9;
		for (int i = 0; i < 4096; i++)
			shadow[12'(i)] = 16'($random(seed));
		dramReadData <= '0;
		dramDtack_L  <= 1'b1;
		dramCas_L    <= 1'b1;
		dramRas_L    <= 1'b1;
		forever begin
			@(negedge Clock);	// sample where the cache outputs are settled
			if (!dramSelect_L && dramWe_L) begin
				fillCount++;
				lastVictim = dut0.victimWay;	// sampled in the lookup cycle
				fillLine   = dramAddr[12:4];
				if (dramAddr[31:4] !== cpuAddr[31:4]) begin
					dramErrors++;
					$display("Error at %0t ns: fill address %h not in line of %h",
						$time, dramAddr, cpuAddr);
				end
				@(posedge Clock);
				dramCas_L <= 1'b0;	// refresh first, RAS low, must be ignored
				dramRas_L <= 1'b0;
				@(posedge Clock);
				dramRas_L <= 1'b1;	// real CAS read
				@(posedge Clock);
				dramCas_L <= 1'b1;
				repeat (CasLatency - 1) @(posedge Clock);
				for (int i = 0; i < 8; i++) begin
					dramReadData <= shadow[{fillLine, 3'(i)}];	// one word per cycle
					@(posedge Clock);
				end
				waitRelease("line fill");
			end else if (!dramSelect_L && !dramWe_L) begin
				if (dramAddr !== cpuAddr || dramWriteData !== cpuWriteData ||
					dramUds_L !== uds_L || dramLds_L !== lds_L || dramAs_L !== 1'b0) begin
					dramErrors++;
					$display("Error at %0t ns: write to %h did not pass through", $time, cpuAddr);
				end
				wordAddr = dramAddr[12:1];
				if (!dramUds_L)
					shadow[wordAddr][15:8] = dramWriteData[15:8];	// upper byte lane
				if (!dramLds_L)
					shadow[wordAddr][7:0] = dramWriteData[7:0];
				repeat (2) @(posedge Clock);
				dramDtack_L <= 1'b0;
				waitRelease("write");
				@(posedge Clock);
				dramDtack_L <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// CPU bus driver
	////////////////////////////////////////////////////////////
	// counts negedges until dtack_L is low, first one included
	task automatic waitDtack(input bit followDram, output int cycles);
		cycles = 0;
		do begin
			@(negedge Clock);
			cycles++;
			if (followDram && dtack_L !== dramDtack_L) begin
				errors++;
				$display("Error at %0t ns: dtack_L %b does not follow dramDtack_L %b",
					$time, dtack_L, dramDtack_L);
			end
		end while (dtack_L && cycles < MaxWait);
		if (dtack_L) begin
			timeouts++;
			$display("Timed out after %0d cycles waiting for dtack_L on a CPU access", MaxWait);
		end
	endtask

	// expWay below zero skips the victim check
	// strobes is {uds_L, lds_L}
	task automatic readWord(input logic [31:0] addr, input bit expectHit, input int expWay,
		input logic [1:0] strobes);
		int          cycles;
		int          fillsBefore;
		logic [15:0] expected;
		fillsBefore = fillCount;
		@(posedge Clock);
		cpuAddr <= addr;
		we_L    <= 1'b1;
		uds_L   <= strobes[1];
		lds_L   <= strobes[0];
		as_L    <= 1'b0;
		waitDtack(1'b0, cycles);
		expected = shadow[addr[12:1]];
		if (cpuReadData !== expected) begin
			errors++;
			$display("Error at %0t ns: read of %h returned %h, expected %h",
				$time, addr, cpuReadData, expected);
		end
		if (expectHit && (fillCount != fillsBefore || cycles != 2)) begin
			errors++;	// a hit acks in the lookup cycle, no DRAM access
			$display("Error at %0t ns: read of %h did not hit in one cycle", $time, addr);
		end
		if (!expectHit && fillCount != fillsBefore + 1) begin
			errors++;
			$display("Error at %0t ns: read of %h did not fill one line", $time, addr);
		end
		if (!expectHit && expWay >= 0 && lastVictim !== 2'(expWay)) begin
			errors++;
			$display("Error at %0t ns: read of %h filled way %0d, expected way %0d",
				$time, addr, lastVictim, expWay);
		end
		repeat (2) @(posedge Clock);	// CPU holds the cycle so dtack_L must stay low
		as_L  <= 1'b1;
		uds_L <= 1'b1;
		lds_L <= 1'b1;
	endtask

	task automatic writeWord(input logic [31:0] addr, input logic [15:0] data,
		input logic uds, input logic lds);
		int cycles;
		@(posedge Clock);
		cpuAddr      <= addr;
		cpuWriteData <= data;
		we_L         <= 1'b0;
		uds_L        <= uds;
		lds_L        <= lds;
		as_L         <= 1'b0;
		waitDtack(1'b1, cycles);
		@(posedge Clock);
		as_L  <= 1'b1;	// we_L stays low, next access sets it
		uds_L <= 1'b1;
		lds_L <= 1'b1;
		@(posedge Clock);	// DRAM ack drops before the next access
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	initial begin : stimulus
		Reset_L       <= 1'b0;
		cpuAddr       <= '0;
		cpuWriteData  <= '0;
		as_L          <= 1'b1;
		uds_L         <= 1'b1;
		lds_L         <= 1'b1;
		we_L          <= 1'b1;
		dramSelectCpu <= 1'b1;
		repeat (3) @(posedge Clock);
		Reset_L <= 1'b1;
		repeat (10) @(posedge Clock);	// sweep is 8 cycles

		readWord(32'h0046, 1'b0, 0, 2'b00);	// cold miss after the sweep
		readWord(32'h004c, 1'b1, -1, 2'b00);	// same line
		readWord(32'h0040, 1'b1, -1, 2'b00);
		writeWord(32'h0048, 16'ha5c3, 1'b0, 1'b1);	// upper byte only
		readWord(32'h0048, 1'b0, 2, 2'b01);	// upper byte read of the invalidated line
		writeWord(32'h0500, 16'h3c5a, 1'b1, 1'b0);	// not cached, lower byte
		readWord(32'h0500, 1'b0, 0, 2'b00);

		// five lines in set 2, tree order 0 2 1 3 then back to 0
		readWord(32'h0122, 1'b0, 0, 2'b00);
		readWord(32'h01a4, 1'b0, 2, 2'b00);
		readWord(32'h022e, 1'b0, 1, 2'b00);
		readWord(32'h02a8, 1'b0, 3, 2'b00);
		readWord(32'h0320, 1'b0, 0, 2'b00);	// evicts A
		readWord(32'h01a0, 1'b1, -1, 2'b00);
		readWord(32'h0120, 1'b0, 1, 2'b00);	// A comes back over C
		readWord(32'h02ae, 1'b1, -1, 2'b00);
		repeat (2) @(posedge Clock);

		$display("errors %0d, timeouts %0d, DRAM errors %0d, DRAM timeouts %0d, asserts %0d",
			errors, timeouts, dramErrors, dramTimeouts, dut0.props0.failCount);
		if (errors + timeouts + dramErrors + dramTimeouts + dut0.props0.failCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
